// File: design/cache_pkg.sv
package cache_pkg;

    ////////////////////
    // cache geometry
    ////////////////////

    // 16 byte lines, 32 sets and 2 ways give 1 KB of data storage
    localparam int OFFSET_BITS    = 4;
    localparam int SET_BITS       = 5;
    localparam int NUM_SETS       = 2 ** SET_BITS;
    localparam int WORDS_PER_LINE = (2 ** OFFSET_BITS) / 4;
    localparam int NUM_WAYS       = 2;
    localparam int TAG_BITS       = 32 - OFFSET_BITS - SET_BITS;

    ////////////////////
    // types
    ////////////////////

    typedef logic [31:0]           word_t;
    typedef logic [31:0]           addr_t;
    typedef logic [3:0]            mask_t;
    // address fields, tag in [31:9], set in [8:4] and word in [3:2]
    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [SET_BITS-1:0]   set_t;
    typedef logic [1:0]            word_idx_t;
    typedef logic                  way_t;

    // the controller either serves hits or is fetching one line
    typedef enum logic {
        LOOKUP,
        FILL
    } fill_state_t;

    // replace the bytes of old_word selected by mask with those of new_word
    function automatic word_t byte_merge(input word_t old_word, input word_t new_word,
                                         input mask_t mask);
        word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

endpackage

// File: design/cache_tag_array.sv
`timescale 1ns/1ps

module cache_tag_array
    import cache_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,
    // address currently looked up by the controller
    input  addr_t i_lookup_addr,
    // tag install at the end of a line fill
    input  logic  i_install,
    input  way_t  i_install_way,
    input  set_t  i_install_set,
    input  tag_t  i_install_tag,
    // lookup result
    output logic  o_hit,
    output way_t  o_hit_way
);
    tag_t                tags  [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0] valid [NUM_SETS];
    set_t                lookup_set;
    tag_t                lookup_tag;
    logic [NUM_WAYS-1:0] way_match;

    assign lookup_set = i_lookup_addr[OFFSET_BITS +: SET_BITS];
    assign lookup_tag = i_lookup_addr[OFFSET_BITS + SET_BITS +: TAG_BITS];

    // compare the lookup tag against both ways of the indexed set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_match[w] = valid[lookup_set][w] && (tags[w][lookup_set] == lookup_tag);
        end
    end

    // a line is never installed in both ways, so at most one bit is set
    assign o_hit     = |way_match;
    // with two ways the hit way is simply the match bit of way 1
    assign o_hit_way = way_match[1];

    ////////////////////
    // valid bits
    ////////////////////

    // the whole cache starts out empty
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
            end
        end else if (i_install) begin
            valid[i_install_set][i_install_way] <= 1'b1;
        end
    end

    // tags only mean something once the matching valid bit is set
    always_ff @(posedge i_clk) begin
        if (i_install) begin
            tags[i_install_way][i_install_set] <= i_install_tag;
        end
    end

endmodule

// File: design/cache_data_array.sv
`timescale 1ns/1ps

module cache_data_array
    import cache_pkg::*;
(
    input  logic      i_clk,
    // read port, addressed by the lookup address and the hit way
    input  addr_t     i_rd_addr,
    input  way_t      i_rd_way,
    output word_t     o_rd_data,
    // merged word, which is also the write-through value for store hits
    output word_t     o_merged,
    // write port, used by store hits and by fill returns
    input  logic      i_wr_en,
    input  way_t      i_wr_way,
    input  set_t      i_wr_set,
    input  word_idx_t i_wr_word,
    input  word_t     i_wr_data,
    input  mask_t     i_wr_mask
);
    // one word per way, set and word slot
    word_t     lines [NUM_WAYS][NUM_SETS][WORDS_PER_LINE];
    set_t      rd_set;
    word_idx_t rd_word;
    word_t     wr_old;

    ////////////////////
    // read side
    ////////////////////

    assign rd_set  = i_rd_addr[OFFSET_BITS +: SET_BITS];
    // word slot sits just below the set index
    assign rd_word = i_rd_addr[OFFSET_BITS-1 -: $bits(word_idx_t)];

    // combinational read so that a load hit returns in its own cycle
    assign o_rd_data = lines[i_rd_way][rd_set][rd_word];

    ////////////////////
    // write side
    ////////////////////

    // current contents of the slot about to be written
    assign wr_old = lines[i_wr_way][i_wr_set][i_wr_word];

    // fill returns come with a full mask and replace the whole word,
    // store hits only replace the bytes they enable
    assign o_merged = byte_merge(wr_old, i_wr_data, i_wr_mask);

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            lines[i_wr_way][i_wr_set][i_wr_word] <= o_merged;
        end
    end

endmodule

// File: design/cache_nmru.sv
`timescale 1ns/1ps

module cache_nmru
    import cache_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst,
    // set being looked up and the way that would be replaced in it
    input  set_t i_set,
    output way_t o_victim,
    // completed hit or completed fill
    input  logic i_touch,
    input  set_t i_touch_set,
    input  way_t i_touch_way
);
    // one bit per set naming the way that was not used most recently
    logic [NUM_SETS-1:0] victim_bits;

    assign o_victim = victim_bits[i_set];

    // after reset every set replaces way 0 first
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            victim_bits <= '0;
        end else if (i_touch) begin
            // point at the other way of the pair
            victim_bits[i_touch_set] <= ~i_touch_way;
        end
    end

endmodule

// File: design/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    // hart side
    input  addr_t     i_req_addr,
    input  logic      i_req_ren,
    input  logic      i_req_wen,
    input  mask_t     i_req_mask,
    input  word_t     i_req_wdata,
    output logic      o_busy,
    // memory side
    input  logic      i_mem_ready,
    input  logic      i_mem_valid,
    input  word_t     i_mem_rdata,
    output addr_t     o_mem_addr,
    output logic      o_mem_ren,
    output logic      o_mem_wen,
    output word_t     o_mem_wdata,
    // lookup results from the tag array, nmru and data array
    input  logic      i_hit,
    input  way_t      i_hit_way,
    input  way_t      i_victim,
    input  word_t     i_merged,
    output addr_t     o_lookup_addr,
    // data array write port
    output logic      o_wr_en,
    output way_t      o_wr_way,
    output set_t      o_wr_set,
    output word_idx_t o_wr_word,
    output word_t     o_wr_data,
    output mask_t     o_wr_mask,
    // tag install and replacement update
    output logic      o_install,
    output tag_t      o_install_tag,
    output logic      o_touch,
    output set_t      o_touch_set,
    output way_t      o_touch_way
);
    fill_state_t                  state;
    fill_state_t                  next_state;
    // captured miss address and the way chosen to receive the line
    addr_t                        miss_addr;
    way_t                         miss_way;
    // issued reads count up to four, the top bit marks all issued
    logic [$bits(word_idx_t):0]   issue_cnt;
    word_idx_t                    ret_cnt;
    logic                         capture;
    logic                         issue;
    logic                         fill_ret;
    set_t                         req_set;
    word_idx_t                    req_word;
    set_t                         miss_set;

    assign req_set  = i_req_addr[OFFSET_BITS +: SET_BITS];
    assign req_word = i_req_addr[OFFSET_BITS-1 -: $bits(word_idx_t)];
    assign miss_set = miss_addr[OFFSET_BITS +: SET_BITS];

    // the arrays see the hart address in lookup and the held miss address during a fill
    assign o_lookup_addr = (state == FILL) ? miss_addr : i_req_addr;
    assign o_install_tag = miss_addr[OFFSET_BITS + SET_BITS +: TAG_BITS];
    // only sampled by memory together with o_mem_wen on a store hit
    assign o_mem_wdata   = i_merged;
    // replacement is updated for the same way and set that gets written
    assign o_touch_set   = o_wr_set;
    assign o_touch_way   = o_wr_way;
    assign fill_ret      = (state == FILL) && i_mem_valid;

    ////////////////////
    // next state and outputs
    ////////////////////

    always_comb begin
        next_state = state;
        o_busy     = 1'b0;
        o_mem_addr = i_req_addr;
        o_mem_ren  = 1'b0;
        o_mem_wen  = 1'b0;
        o_wr_en    = 1'b0;
        o_wr_way   = i_hit_way;
        o_wr_set   = req_set;
        o_wr_word  = req_word;
        o_wr_data  = i_req_wdata;
        o_wr_mask  = i_req_mask;
        o_install  = 1'b0;
        o_touch    = 1'b0;
        capture    = 1'b0;
        issue      = 1'b0;
        case (state)
            LOOKUP: begin
                if ((i_req_ren || i_req_wen) && !i_hit) begin
                    // load or store miss, stall the hart and go fetch the line
                    o_busy     = 1'b1;
                    capture    = 1'b1;
                    next_state = FILL;
                end else if (i_req_ren) begin
                    // read hit, data is already on o_res_rdata
                    o_touch = i_hit;
                end else if (i_req_wen && i_mem_ready) begin
                    // store hit, write the merged word to the line and through to memory
                    o_mem_wen = 1'b1;
                    o_wr_en   = 1'b1;
                    o_touch   = 1'b1;
                end else if (i_req_wen) begin
                    // memory cannot take the write through yet so the hart retries
                    o_busy = 1'b1;
                end
            end
            FILL: begin
                o_busy     = 1'b1;
                // line base plus the next word to issue, byte offset is always zero
                o_mem_addr = {miss_addr[$bits(addr_t)-1:OFFSET_BITS],
                              issue_cnt[$bits(word_idx_t)-1:0], 2'b00};
                o_wr_way   = miss_way;
                o_wr_set   = miss_set;
                o_wr_word  = ret_cnt;
                o_wr_data  = i_mem_rdata;
                o_wr_mask  = '1;
                if (!issue_cnt[$bits(word_idx_t)] && i_mem_ready) begin
                    o_mem_ren = 1'b1;
                    issue     = 1'b1;
                end
                // returns arrive in order so ret_cnt is the word slot
                if (i_mem_valid) begin
                    o_wr_en = 1'b1;
                    if (ret_cnt == word_idx_t'(WORDS_PER_LINE - 1)) begin
                        o_install  = 1'b1;
                        o_touch    = 1'b1;
                        next_state = LOOKUP;
                    end
                end
            end
            default: begin
                next_state = LOOKUP;
            end
        endcase
    end

    ////////////////////
    // state and counters
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state     <= LOOKUP;
            issue_cnt <= '0;
            ret_cnt   <= '0;
        end else begin
            state <= next_state;
            if (capture) begin
                issue_cnt <= '0;
                ret_cnt   <= '0;
            end else begin
                if (issue) begin
                    issue_cnt <= issue_cnt + 1'b1;
                end
                if (fill_ret) begin
                    ret_cnt <= ret_cnt + 1'b1;
                end
            end
        end
    end

    // held for the whole fill, the victim comes from the set of the missing address
    always_ff @(posedge i_clk) begin
        if (capture) begin
            miss_addr <= i_req_addr;
            miss_way  <= i_victim;
        end
    end

endmodule

// File: design/cache_top.sv
`timescale 1ns/1ps

module cache_top
    import cache_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,
    // hart side
    input  addr_t i_req_addr,
    input  logic  i_req_ren,
    input  logic  i_req_wen,
    input  mask_t i_req_mask,
    input  word_t i_req_wdata,
    output logic  o_busy,
    output word_t o_res_rdata,
    // backing memory side
    input  logic  i_mem_ready,
    input  logic  i_mem_valid,
    input  word_t i_mem_rdata,
    output addr_t o_mem_addr,
    output logic  o_mem_ren,
    output logic  o_mem_wen,
    output word_t o_mem_wdata
);
    addr_t     lookup_addr;
    set_t      lookup_set;
    logic      hit;
    way_t      hit_way;
    way_t      victim;
    word_t     merged;
    logic      wr_en;
    way_t      wr_way;
    set_t      wr_set;
    word_idx_t wr_word;
    word_t     wr_data;
    mask_t     wr_mask;
    logic      install;
    tag_t      install_tag;
    logic      touch;
    set_t      touch_set;
    way_t      touch_way;

    assign lookup_set = lookup_addr[OFFSET_BITS +: SET_BITS];

    cache_ctrl u_ctrl (
        .i_clk, .i_rst,
        .i_req_addr, .i_req_ren, .i_req_wen, .i_req_mask, .i_req_wdata, .o_busy,
        .i_mem_ready, .i_mem_valid, .i_mem_rdata,
        .o_mem_addr, .o_mem_ren, .o_mem_wen, .o_mem_wdata,
        .i_hit(hit), .i_hit_way(hit_way), .i_victim(victim), .i_merged(merged),
        .o_lookup_addr(lookup_addr),
        .o_wr_en(wr_en), .o_wr_way(wr_way), .o_wr_set(wr_set), .o_wr_word(wr_word),
        .o_wr_data(wr_data), .o_wr_mask(wr_mask),
        .o_install(install), .o_install_tag(install_tag),
        .o_touch(touch), .o_touch_set(touch_set), .o_touch_way(touch_way)
    );

    // a tag is installed into the same way and set the fill writes
    cache_tag_array u_tags (
        .i_clk, .i_rst,
        .i_lookup_addr(lookup_addr),
        .i_install(install), .i_install_way(wr_way), .i_install_set(wr_set),
        .i_install_tag(install_tag),
        .o_hit(hit), .o_hit_way(hit_way)
    );

    // the read word goes straight back to the hart
    cache_data_array u_data (
        .i_clk,
        .i_rd_addr(lookup_addr), .i_rd_way(hit_way), .o_rd_data(o_res_rdata),
        .o_merged(merged),
        .i_wr_en(wr_en), .i_wr_way(wr_way), .i_wr_set(wr_set), .i_wr_word(wr_word),
        .i_wr_data(wr_data), .i_wr_mask(wr_mask)
    );

    cache_nmru u_nmru (
        .i_clk, .i_rst,
        .i_set(lookup_set), .o_victim(victim),
        .i_touch(touch), .i_touch_set(touch_set), .i_touch_way(touch_way)
    );

endmodule

// File: sim/cache_assert.sv
`timescale 1ns/1ps

module cache_assert
    import cache_pkg::*;
(
    input logic        i_clk,
    input logic        i_rst,
    input logic        i_mem_ren,
    input logic        i_mem_wen,
    input logic        i_mem_ready,
    input logic        i_busy,
    input fill_state_t i_state
);
    // the memory port carries one kind of request per cycle
    mem_one_op: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_mem_ren && i_mem_wen))
        else $error("memory read and write requested in the same cycle");

    // memory only accepts a request together with ready
    mem_needs_ready: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_mem_ren || i_mem_wen) |-> i_mem_ready)
        else $error("memory request issued without ready");

    // the hart stays stalled for the whole line fill
    busy_in_fill: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_state == FILL) |-> i_busy)
        else $error("busy dropped during a line fill");

endmodule

bind cache_ctrl cache_assert u_assert (
    .i_clk, .i_rst,
    .i_mem_ren(o_mem_ren), .i_mem_wen(o_mem_wen), .i_mem_ready,
    .i_busy(o_busy), .i_state(state)
);

// File: sim/cache_mem_model.sv
`timescale 1ns/1ps

module cache_mem_model
    import cache_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,
    // request side, driven by the cache
    input  addr_t i_addr,
    input  logic  i_ren,
    input  logic  i_wen,
    input  word_t i_wdata,
    // ready and read return, driven back to the cache
    output logic  o_ready,
    output logic  o_valid,
    output word_t o_rdata
);
    // backing words, any address never written reads as its fill pattern
    word_t       words [addr_t];
    // accepted reads waiting for their return cycle, kept in request order
    addr_t       rd_addr_q [$];
    int unsigned rd_due_q [$];
    int unsigned cycle;
    int unsigned ready_roll;
    addr_t       head;

    // the pattern mixes every address bit so that aliasing lines differ
    function automatic word_t read_word(input addr_t a);
        if (words.exists(a)) begin
            return words[a];
        end
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    initial begin
        o_ready = 1'b0;
        o_valid = 1'b0;
        o_rdata = '0;
        cycle   = 0;
    end

    always @(posedge i_clk) begin
        if (i_rst) begin
            rd_addr_q.delete();
            rd_due_q.delete();
            cycle = 0;
        end else begin
            if (i_wen && o_ready) begin
                words[i_addr] = i_wdata;
            end
            // each read gets its own latency of 1 to 4 cycles
            if (i_ren && o_ready) begin
                rd_addr_q.push_back(i_addr);
                rd_due_q.push_back(cycle + $urandom_range(4, 1));
            end
            cycle = cycle + 1;
        end
        #1;
        // ready is high about three cycles in four
        ready_roll = $urandom_range(3);
        o_ready    = (ready_roll != 0);
        o_valid    = 1'b0;
        // a later read never overtakes the head, so returns stay in order
        if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
            head = rd_addr_q.pop_front();
            void'(rd_due_q.pop_front());
            o_valid = 1'b1;
            o_rdata = read_word(head);
        end
    end

endmodule

// File: sim/cache_tb.sv
`timescale 1ns/1ps

module cache_tb
    import cache_pkg::*;
();
    localparam int NUM_REQS = 400;

    logic  i_clk = 1'b0;
    logic  i_rst;
    addr_t i_req_addr;
    logic  i_req_ren;
    logic  i_req_wen;
    mask_t i_req_mask;
    word_t i_req_wdata;
    logic  o_busy;
    word_t o_res_rdata;
    logic  i_mem_ready;
    logic  i_mem_valid;
    word_t i_mem_rdata;
    addr_t o_mem_addr;
    logic  o_mem_ren;
    logic  o_mem_wen;
    word_t o_mem_wdata;

    // memory contents as the hart should see them
    word_t       model_mem [addr_t];
    // tag store and replacement state predicted for the cache
    tag_t        model_tag [NUM_SETS][NUM_WAYS];
    logic        model_valid [NUM_SETS][NUM_WAYS];
    way_t        model_victim [NUM_SETS];
    // read addresses seen on the memory port, consumed after each fill
    addr_t       fill_q [$];
    int unsigned writes_seen = 0;
    int unsigned stores_done = 0;

    cache_top uut (.*);

    cache_mem_model mem (
        .i_clk, .i_rst,
        .i_addr(o_mem_addr), .i_ren(o_mem_ren), .i_wen(o_mem_wen), .i_wdata(o_mem_wdata),
        .o_ready(i_mem_ready), .o_valid(i_mem_valid), .o_rdata(i_mem_rdata)
    );

    always #5 i_clk = ~i_clk;

    // memory port traffic, sampled mid cycle where everything has settled
    always @(negedge i_clk) begin
        if (!i_rst && o_mem_ren) begin
            fill_q.push_back(o_mem_addr);
        end
        if (!i_rst && o_mem_wen) begin
            writes_seen++;
        end
    end

    // a request costs well under 40 cycles even with slow memory
    initial begin
        repeat (NUM_REQS * 40) @(posedge i_clk);
        fail_now("watchdog expired before all requests completed");
    end

    ////////////////////
    // checks
    ////////////////////

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    ////////////////////
    // model
    ////////////////////

    function automatic word_t model_word(input addr_t a);
        if (model_mem.exists(a)) begin
            return model_mem[a];
        end
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    // each mask bit selects one byte lane of the new word
    function automatic word_t apply_mask(input word_t old_w, input word_t new_w, input mask_t m);
        word_t lanes;
        lanes = {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
        return (old_w & ~lanes) | (new_w & lanes);
    endfunction

    // a miss names the victim way, a hit names the matching way
    function automatic void predict(input tag_t tag, input set_t set_idx,
                                    output logic hit, output way_t way);
        hit = 1'b0;
        way = model_victim[set_idx];
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (model_valid[set_idx][w] && model_tag[set_idx][w] == tag) begin
                hit = 1'b1;
                way = way_t'(w);
            end
        end
    endfunction

    // wait out a fill, check its four reads and install the line in the model
    task automatic finish_fill(input addr_t addr, input set_t set_idx, input tag_t tag);
        addr_t base;
        way_t  victim;
        base   = {addr[31:4], 4'h0};
        victim = model_victim[set_idx];
        @(negedge i_clk);
        while (o_busy) begin
            @(negedge i_clk);
        end
        if (fill_q.size() != WORDS_PER_LINE) begin
            fail_now("a line fill did not issue exactly four memory reads");
        end
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            check_addr("o_mem_addr", fill_q.pop_front(), base + addr_t'(4 * k));
        end
        model_tag[set_idx][victim]   = tag;
        model_valid[set_idx][victim] = 1'b1;
        model_victim[set_idx]        = ~victim;
        @(posedge i_clk);
        #1;
    endtask

    // present one hart request until it completes, following the stall rules
    task automatic run_request(input logic is_write, input addr_t addr, input mask_t mask,
                               input word_t wdata);
        tag_t  tag;
        set_t  set_idx;
        logic  hit;
        way_t  way;
        logic  done;
        word_t merged_word;
        tag         = addr[31:9];
        set_idx     = addr[8:4];
        done        = 1'b0;
        i_req_addr  = addr;
        i_req_mask  = mask;
        i_req_wdata = wdata;
        while (!done) begin
            i_req_ren = !is_write;
            i_req_wen = is_write;
            predict(tag, set_idx, hit, way);
            @(negedge i_clk);
            // a store hit is refused while memory is not ready
            check_flag("o_busy", o_busy, !hit || (is_write && !i_mem_ready));
            if (!o_busy) begin
                if (is_write) begin
                    merged_word = apply_mask(model_word(addr), wdata, mask);
                    check_flag("o_mem_wen", o_mem_wen, 1'b1);
                    check_addr("o_mem_addr", o_mem_addr, addr);
                    check_word("o_mem_wdata", o_mem_wdata, merged_word);
                    model_mem[addr] = merged_word;
                    stores_done++;
                end else begin
                    check_flag("o_mem_wen", o_mem_wen, 1'b0);
                    check_word("o_res_rdata", o_res_rdata, model_word(addr));
                end
                model_victim[set_idx] = ~way;
                done = 1'b1;
            end
            @(posedge i_clk);
            #1;
            // a refused store hit stays asserted, anything else drops
            if (done || !hit) begin
                i_req_ren = 1'b0;
                i_req_wen = 1'b0;
            end
            if (!hit) begin
                finish_fill(addr, set_idx, tag);
            end
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        int unsigned tag_sel;
        int unsigned set_sel;
        int unsigned word_sel;
        int unsigned mask_kind;
        logic        is_write;
        addr_t       addr;
        mask_t       mask;
        word_t       wdata;
        void'($urandom(86));
        i_rst       = 1'b1;
        i_req_addr  = '0;
        i_req_ren   = 1'b0;
        i_req_wen   = 1'b0;
        i_req_mask  = '0;
        i_req_wdata = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            model_victim[s] = 1'b0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
            end
        end
        repeat (2) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        // idle cache right after reset
        @(negedge i_clk);
        check_flag("o_busy", o_busy, 1'b0);
        check_flag("o_mem_ren", o_mem_ren, 1'b0);
        check_flag("o_mem_wen", o_mem_wen, 1'b0);
        @(posedge i_clk);
        #1;
        for (int n = 0; n < NUM_REQS; n++) begin
            // four tags over four sets keep both ways of each set contended
            tag_sel   = $urandom_range(3);
            set_sel   = $urandom_range(3);
            word_sel  = $urandom_range(3);
            addr      = 32'h0000_4000 + tag_sel * 512 + set_sel * 16 + word_sel * 4;
            is_write  = ($urandom_range(1) == 1);
            mask_kind = $urandom_range(2);
            if (mask_kind == 0) begin
                mask = mask_t'(4'b0001 << $urandom_range(3));
            end else if (mask_kind == 1) begin
                mask = ($urandom_range(1) == 1) ? 4'b1100 : 4'b0011;
            end else begin
                mask = 4'hf;
            end
            wdata = $urandom;
            run_request(is_write, addr, mask, wdata);
        end
        // every write belongs to a store and every read to a fill already checked
        if (writes_seen == stores_done && fill_q.size() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_now("memory traffic did not match the completed requests");
        end
    end

endmodule

// File: cache.f
design/cache_pkg.sv
design/cache_tag_array.sv
design/cache_data_array.sv
design/cache_nmru.sv
design/cache_ctrl.sv
design/cache_top.sv
sim/cache_assert.sv
sim/cache_mem_model.sv
sim/cache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cache_tb -Mdir obj_dir -f cache.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcache_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1
